//--- asyncFifo.f
rtl/asyncFifoPkg.sv
rtl/fifoWritePtr.sv
rtl/fifoReadPtr.sv
rtl/ptrSync.sv
rtl/fifoMem.sv
rtl/asyncFifo.sv
testbench/asyncFifoTb.sv

//--- rtl/asyncFifo.sv
`timescale 1ns/10ps
`default_nettype none

module asyncFifo (
    input  logic               Wclk,
    input  logic               Wrst,
    input  logic               Winc,
    input  asyncFifoPkg::dataT Wdata,
    output logic               Wfull,
    input  logic               Rclk,
    input  logic               Rrst,
    input  logic               Rinc,
    output asyncFifoPkg::dataT Rdata,
    output logic               Rempty
);
    import asyncFifoPkg::*;

    // Write-domain nets
    addrT waddr;
    ptrT  wptrGray;
    ptrT  wsyncRptr;
    logic wen;

    // Read-domain nets
    addrT raddr;
    ptrT  rptrGray;
    ptrT  rsyncWptr;

    // Write pointer and full flag
    fifoWritePtr writePtr_i (
        .Wclk      (Wclk),
        .Wrst      (Wrst),
        .Winc      (Winc),
        .WsyncRptr (wsyncRptr),
        .Waddr     (waddr),
        .WptrGray  (wptrGray),
        .Wfull     (Wfull),
        .Wen       (wen)
    );

    // Read pointer and empty flag
    fifoReadPtr readPtr_i (
        .Rclk      (Rclk),
        .Rrst      (Rrst),
        .Rinc      (Rinc),
        .RsyncWptr (rsyncWptr),
        .Raddr     (raddr),
        .RptrGray  (rptrGray),
        .Rempty    (Rempty)
    );

    // Read pointer into the write domain
    ptrSync syncR2w_i (
        .clk    (Wclk),
        .rstN   (Wrst),
        .ptrIn  (rptrGray),
        .ptrOut (wsyncRptr)
    );

    // Write pointer into the read domain
    ptrSync syncW2r_i (
        .clk    (Rclk),
        .rstN   (Rrst),
        .ptrIn  (wptrGray),
        .ptrOut (rsyncWptr)
    );

    // Dual-clock storage
    fifoMem mem_i (
        .Wclk  (Wclk),
        .Wen   (wen),
        .Waddr (waddr),
        .Wdata (Wdata),
        .Raddr (raddr),
        .Rdata (Rdata)
    );

endmodule

`default_nettype wire

//--- rtl/asyncFifoPkg.sv
`default_nettype none

package asyncFifoPkg;

    // Memory address bits
    localparam int AddrWidth = 4;

    // Word count, always a power of two
    localparam int Depth = 1 << AddrWidth;

    // Payload bits per word
    localparam int DataWidth = 8;

    // One stored word
    typedef logic [DataWidth-1:0] dataT;

    // Index into the storage array
    typedef logic [AddrWidth-1:0] addrT;

    // Binary count or Gray pointer
    // Extra top bit is the wrap parity
    typedef logic [AddrWidth:0] ptrT;

endpackage

`default_nettype wire

//--- rtl/fifoMem.sv
`timescale 1ns/10ps
`default_nettype none

module fifoMem (
    input  logic               Wclk,
    input  logic               Wen,
    input  asyncFifoPkg::addrT Waddr,
    input  asyncFifoPkg::dataT Wdata,
    input  asyncFifoPkg::addrT Raddr,
    output asyncFifoPkg::dataT Rdata
);
    import asyncFifoPkg::*;

    // Storage array, one word per slot
    dataT mem [Depth];

    // Write port in the write domain
    // Wen already carries the full test
    always_ff @(posedge Wclk)
    begin
        if (Wen)
            mem[Waddr] <= Wdata;
    end

    // Show-ahead read, no clock on this port
    assign Rdata = mem[Raddr];

endmodule

`default_nettype wire

//--- rtl/fifoReadPtr.sv
`timescale 1ns/10ps
`default_nettype none

module fifoReadPtr (
    input  logic               Rclk,
    input  logic               Rrst,
    input  logic               Rinc,
    input  asyncFifoPkg::ptrT  RsyncWptr,
    output asyncFifoPkg::addrT Raddr,
    output asyncFifoPkg::ptrT  RptrGray,
    output logic               Rempty
);
    import asyncFifoPkg::*;

    // Binary count mirrors the write side
    ptrT rBin;
    ptrT rBinNext;
    ptrT rGrayNext;
    logic rEn;
    logic emptyNext;

    // Read consumed only while data is present
    assign rEn = Rinc & ~Rempty;

    // Next count and its Gray form
    assign rBinNext  = rBin + ptrT'(rEn);
    assign rGrayNext = (rBinNext >> 1) ^ rBinNext;

    // Empty once the next pointer catches the synced write pointer
    assign emptyNext = (rGrayNext == RsyncWptr);

    // Show-ahead address for the memory
    assign Raddr = rBin[AddrWidth-1:0];

    // Pointers step on the consuming edge
    always_ff @(posedge Rclk or negedge Rrst)
    begin
        if (!Rrst)
        begin
            rBin     <= '0;
            RptrGray <= '0;
        end
        else
        begin
            rBin     <= rBinNext;
            RptrGray <= rGrayNext;
        end
    end

    // Look-ahead empty, set out of reset
    always_ff @(posedge Rclk or negedge Rrst)
    begin
        if (!Rrst)
            Rempty <= 1'b1;
        else
            Rempty <= emptyNext;
    end

    // One Gray bit per edge at most
    assert property (@(posedge Rclk) disable iff (!Rrst)
        $countones(RptrGray ^ $past(RptrGray)) <= 1);

    // Data shown only while the synced write pointer is ahead
    assert property (@(posedge Rclk) disable iff (!Rrst)
        !Rempty |-> (RptrGray != RsyncWptr));

endmodule

`default_nettype wire

//--- rtl/fifoWritePtr.sv
`timescale 1ns/10ps
`default_nettype none

module fifoWritePtr (
    input  logic               Wclk,
    input  logic               Wrst,
    input  logic               Winc,
    input  asyncFifoPkg::ptrT  WsyncRptr,
    output asyncFifoPkg::addrT Waddr,
    output asyncFifoPkg::ptrT  WptrGray,
    output logic               Wfull,
    output logic               Wen
);
    import asyncFifoPkg::*;

    // Binary count, one bit wider than the address
    ptrT wBin;
    ptrT wBinNext;
    ptrT wGrayNext;
    logic fullNext;

    // Write accepted only while not full
    assign Wen = Winc & ~Wfull;

    // Next count and its Gray form
    assign wBinNext  = wBin + ptrT'(Wen);
    assign wGrayNext = (wBinNext >> 1) ^ wBinNext;

    // Full when next pointer is one lap ahead of the read pointer
    // Top two Gray bits inverted, the rest equal
    assign fullNext = (wGrayNext == {~WsyncRptr[AddrWidth:AddrWidth-1],
                                     WsyncRptr[AddrWidth-2:0]});

    // Low address bits drive the memory
    assign Waddr = wBin[AddrWidth-1:0];

    // Both pointers move on the accepting edge
    always_ff @(posedge Wclk or negedge Wrst)
    begin
        if (!Wrst)
        begin
            wBin     <= '0;
            WptrGray <= '0;
        end
        else
        begin
            wBin     <= wBinNext;
            WptrGray <= wGrayNext;
        end
    end

    // Look-ahead full, rises with the word that fills the array
    always_ff @(posedge Wclk or negedge Wrst)
    begin
        if (!Wrst)
            Wfull <= 1'b0;
        else
            Wfull <= fullNext;
    end

    // Not full means the synced read pointer is less than a lap behind
    assert property (@(posedge Wclk) disable iff (!Wrst)
        !Wfull |-> (WptrGray != {~WsyncRptr[AddrWidth:AddrWidth-1],
                                 WsyncRptr[AddrWidth-2:0]}));

    // Gray pointer crossing safety
    assert property (@(posedge Wclk) disable iff (!Wrst)
        $countones(WptrGray ^ $past(WptrGray)) <= 1);

endmodule

`default_nettype wire

//--- rtl/ptrSync.sv
`timescale 1ns/10ps
`default_nettype none

module ptrSync (
    input  logic              clk,
    input  logic              rstN,
    input  asyncFifoPkg::ptrT ptrIn,
    output asyncFifoPkg::ptrT ptrOut
);
    import asyncFifoPkg::*;

    // First stage may go metastable
    ptrT stage1;

    // Gray input, so at most one bit is in flight per source edge
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            stage1 <= '0;
            ptrOut <= '0;
        end
        else
        begin
            stage1 <= ptrIn;
            // Second stage settles the value
            ptrOut <= stage1;
        end
    end

endmodule

`default_nettype wire

//--- runSim.sh
#!/bin/sh
# Build and run the async FIFO testbench with Verilator
# Exit status is nonzero when the build or the simulation fails

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
    --top-module asyncFifoTb \
    -f asyncFifo.f \
    -o simAsyncFifo
status=$?
if [ $status -ne 0 ]; then
    echo "Verilator build failed with status $status"
    exit $status
fi

./obj_dir/simAsyncFifo
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation run ended with status $status"
    exit $status
fi

exit 0

//--- testbench/asyncFifoTb.sv
`timescale 1ns/10ps
`default_nettype none

module asyncFifoTb;
    import asyncFifoPkg::*;

    // Longest wait on any flag, in clock cycles
    localparam int TimeoutCycles = 50;

    logic Wclk;
    logic Wrst;
    logic Winc;
    dataT Wdata;
    logic Wfull;
    logic Rclk;
    logic Rrst;
    logic Rinc;
    dataT Rdata;
    logic Rempty;

    // Reference model, oldest word in front
    dataT refQueue[$];
    logic [31:0] lcgState;

    asyncFifo dut_i (
        .Wclk   (Wclk),
        .Wrst   (Wrst),
        .Winc   (Winc),
        .Wdata  (Wdata),
        .Wfull  (Wfull),
        .Rclk   (Rclk),
        .Rrst   (Rrst),
        .Rinc   (Rinc),
        .Rdata  (Rdata),
        .Rempty (Rempty)
    );

    // Write clock, rising at 5, 15, 25
    always #5 Wclk = ~Wclk;

    // Read clock lags by 3 ns, rising at 8, 18, 28
    always
    begin
        #3 Rclk = ~Rclk;
        #2;
    end

    function automatic logic [31:0] lcgNext(input logic [31:0] state);
        return state * 32'd1664525 + 32'd1013904223;
    endfunction

    task automatic abortRun(input string why);
        $display("%s", why);
        $display("sim failed");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic compareData(input string name, input dataT expected, input dataT actual);
        if (actual !== expected)
            abortRun($sformatf("Fail %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    task automatic compareFlag(input string name, input logic expected, input logic actual);
        if (actual !== expected)
            abortRun($sformatf("Fail %s expected 0x%h actual 0x%h", name, expected, actual));
    endtask

    // Negative expectation leaves the flag unchecked
    function automatic bit flagMatches(input int expected, input logic actual);
        return (expected < 0) || (actual === (expected != 0));
    endfunction

    // Write attempts; keepTrying holds each word until it is accepted
    task automatic writeWords(input int count, input bit keepTrying);
        int i;
        int tries;
        bit accepted;
        dataT word;
        @(posedge Wclk);
        #1;
        for (i = 0; i < count; i++)
        begin
            lcgState = lcgNext(lcgState);
            word = lcgState[23:16];
            Winc = 1'b1;
            Wdata = word;
            tries = 0;
            while (keepTrying && Wfull)
            begin
                if (tries >= TimeoutCycles)
                    abortRun("Wfull stayed high and a stream write was never accepted");
                else
                begin
                    tries++;
                    @(posedge Wclk);
                    #1;
                end
            end
            // Outside a stream the model alone knows when Depth words are held
            if (!keepTrying)
                compareFlag("Wfull", refQueue.size() >= Depth, Wfull);
            // Wfull holds until the edge, so this is the DUT's decision
            accepted = !Wfull;
            @(posedge Wclk);
            #1;
            if (accepted)
                refQueue.push_back(word);
        end
        Winc = 1'b0;
    endtask

    // Read attempts; keepTrying waits until each word is consumed
    task automatic readWords(input int count, input bit keepTrying);
        int i;
        int tries;
        dataT expected;
        @(posedge Rclk);
        #1;
        for (i = 0; i < count; i++)
        begin
            Rinc = 1'b1;
            tries = 0;
            while (keepTrying && Rempty)
            begin
                if (tries >= TimeoutCycles)
                    abortRun("Rempty stayed high and a stream read never got data");
                else
                begin
                    tries++;
                    @(posedge Rclk);
                    #1;
                end
            end
            // Rdata only matters while Rempty is low
            if (!Rempty)
            begin
                if (refQueue.size() == 0)
                    abortRun("DUT shows data while the reference queue is empty");
                else
                begin
                    expected = refQueue.pop_front();
                    compareData("Rdata", expected, Rdata);
                end
            end
            @(posedge Rclk);
            #1;
        end
        Rinc = 1'b0;
    endtask

    task automatic waitFullClear();
        int tries;
        tries = 0;
        while (Wfull)
        begin
            if (tries >= TimeoutCycles)
                abortRun("Wfull never cleared after reads within the timeout");
            else
            begin
                tries++;
                @(posedge Wclk);
                #1;
            end
        end
    endtask

    task automatic waitEmptyClear();
        int tries;
        tries = 0;
        while (Rempty)
        begin
            if (tries >= TimeoutCycles)
                abortRun("Rempty never cleared after a write within the timeout");
            else
            begin
                tries++;
                @(posedge Rclk);
                #1;
            end
        end
    endtask

    // Flags may still be crossing, so give them the timeout to arrive
    task automatic settleFlags(input int expFull, input int expEmpty);
        int tries;
        tries = 0;
        while (!(flagMatches(expFull, Wfull) && flagMatches(expEmpty, Rempty))
               && tries < TimeoutCycles)
        begin
            tries++;
            @(posedge Wclk);
            #1;
        end
        if (expFull >= 0)
            compareFlag("Wfull", expFull != 0, Wfull);
        if (expEmpty >= 0)
            compareFlag("Rempty", expEmpty != 0, Rempty);
    endtask

    task automatic runCommand(input string cmd, input int count, input int expFull,
                              input int expEmpty);
        if (cmd == "write")
            writeWords(count, 1'b0);
        else if (cmd == "read")
            readWords(count, 1'b0);
        else if (cmd == "stream")
        begin
            // Both domains at once, each side moves count words
            fork
                writeWords(count, 1'b1);
                readWords(count, 1'b1);
            join
        end
        else if (cmd == "waitfull")
            waitFullClear();
        else if (cmd == "waitempty")
            waitEmptyClear();
        else
            abortRun($sformatf("Unknown command %s in the test file", cmd));
        settleFlags(expFull, expEmpty);
    endtask

    task automatic runTestFile();
        int fd;
        int fields;
        int lineNo;
        int count;
        int expFull;
        int expEmpty;
        string lineBuf;
        string cmdWord;
        fd = $fopen("testbench/asyncFifoTests.txt", "r");
        if (fd == 0)
            abortRun("Could not open the test file testbench/asyncFifoTests.txt");
        lineNo = 0;
        while ($fgets(lineBuf, fd) != 0)
        begin
            lineNo++;
            cmdWord = "";
            fields = $sscanf(lineBuf, "%s %d %d %d", cmdWord, count, expFull, expEmpty);
            // Blank lines and # comments are skipped
            if (fields > 0 && cmdWord.getc(0) != "#")
            begin
                if (fields == 4)
                    runCommand(cmdWord, count, expFull, expEmpty);
                else
                    abortRun($sformatf("Malformed line %0d in the test file", lineNo));
            end
        end
        $fclose(fd);
    endtask

    initial
    begin
        Wclk = 1'b0;
        Rclk = 1'b1;
        Wrst = 1'b0;
        Rrst = 1'b0;
        Winc = 1'b0;
        Wdata = '0;
        Rinc = 1'b0;
        lcgState = 32'hefbc;
        // Both domains held in reset for 8 cycles
        repeat (8) @(posedge Wclk);
        #1;
        Wrst = 1'b1;
        @(posedge Rclk);
        #1;
        Rrst = 1'b1;
        compareFlag("Rempty", 1'b1, Rempty);
        compareFlag("Wfull", 1'b0, Wfull);
        runTestFile();
        if (refQueue.size() != 0)
            abortRun($sformatf("%0d words never came out of the FIFO", refQueue.size()));
        else
        begin
            $display("sim passed");
            $finish;
        end
    end

endmodule

`default_nettype wire

//--- testbench/asyncFifoTests.txt
# command count Wfull Rempty, flags expected once the command is done
# write and read count clock edges, stream counts words, -1 skips a flag
write 1 0 0
read 1 0 1
write 5 0 0
read 5 0 1
write 20 1 0
write 2 1 0
read 16 0 1
read 4 0 1
write 16 1 0
read 3 -1 0
waitfull 0 0 0
write 3 1 0
read 8 -1 0
waitfull 0 0 0
read 8 0 1
write 1 0 -1
waitempty 0 0 0
read 1 0 1
stream 40 0 1
write 9 0 0
stream 37 0 0
read 9 0 1
stream 50 0 1
